//--- design/dcache_geom_pkg.sv
////////////////////////////////////////
// cache geometry of the L1 data cache memory stage
// shared by the tag path, control and top level
////////////////////////////////////////

package dcache_geom_pkg;

  // 4-way set-associative, 64 sets
  parameter int unsigned NumWays = 4;
  parameter int unsigned NumSets = 64;

  // field widths of a 32-bit address: tag | index | offset
  parameter int unsigned IdxWidth    = 6;
  parameter int unsigned TagWidth    = 22;
  parameter int unsigned WayIdxWidth = 2;

  // set index
  typedef logic [IdxWidth-1:0] cache_idx_t;

  // tag stored per way and set
  typedef logic [TagWidth-1:0] cache_tag_t;

  // one bit per way, used for requests, hits and valid bits
  typedef logic [NumWays-1:0] way_vec_t;

  // binary way number
  typedef logic [WayIdxWidth-1:0] way_idx_t;

endpackage

//--- design/dcache_word_pkg.sv
////////////////////////////////////////
// data word, byte enable and offset types of the data banks
////////////////////////////////////////

package dcache_word_pkg;

  parameter int unsigned NumBanks = 2;
  parameter int unsigned OffWidth = 4;

  typedef logic [63:0]  data_word_t;
  typedef logic [7:0]   word_be_t;
  typedef logic [127:0] line_t;
  typedef logic [15:0]  line_be_t;

  // byte offset in a line, either flat or split into bank and byte in bank
  typedef union packed {
    logic [OffWidth-1:0] flat;
    struct packed {
      logic                bank;
      logic [OffWidth-2:0] byte_sel;
    } fld;
  } cache_off_u;

endpackage

//--- design/dcache_tag_if.sv
////////////////////////////////////////
// tag and valid lookup between control, tag array and compare
////////////////////////////////////////

`timescale 1ns/1ps

interface dcache_tag_if;

  // request side, driven by the control module
  dcache_geom_pkg::way_vec_t   req;
  logic                        we;
  dcache_geom_pkg::cache_idx_t idx;
  dcache_geom_pkg::cache_tag_t wtag;
  dcache_geom_pkg::way_vec_t   wvalid;

  // read side, one cycle after req
  dcache_geom_pkg::cache_tag_t [dcache_geom_pkg::NumWays-1:0] rtag;
  dcache_geom_pkg::way_vec_t                                  rvalid;

  modport ctrl_mp (output req, we, idx, wtag, wvalid);
  modport array_mp (input req, we, idx, wtag, wvalid, output rtag, rvalid);
  modport cmp_mp (input rtag, rvalid);

endinterface

//--- design/dcache_bank_if.sv
////////////////////////////////////////
// per-bank SRAM access between control, data banks and read mux
////////////////////////////////////////

`timescale 1ns/1ps

interface dcache_bank_if;

  // one request per bank, all ways of the bank in parallel
  logic [dcache_word_pkg::NumBanks-1:0] req;
  logic [dcache_word_pkg::NumBanks-1:0] we;
  dcache_geom_pkg::cache_idx_t [dcache_word_pkg::NumBanks-1:0] idx;

  dcache_word_pkg::word_be_t
    [dcache_word_pkg::NumBanks-1:0][dcache_geom_pkg::NumWays-1:0] be;
  dcache_word_pkg::data_word_t
    [dcache_word_pkg::NumBanks-1:0][dcache_geom_pkg::NumWays-1:0] wdata;

  // registered read data
  dcache_word_pkg::data_word_t
    [dcache_word_pkg::NumBanks-1:0][dcache_geom_pkg::NumWays-1:0] rdata;

  modport ctrl_mp (output req, we, idx, be, wdata);
  modport banks_mp (input req, we, idx, be, wdata, output rdata);
  modport cmp_mp (input rdata);

endinterface

//--- design/dcache_access_ctrl.sv
////////////////////////////////////////
// read port arbitration, refill and word-write steering onto the
// tag and bank interfaces, plus the registers of the compare stage
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_access_ctrl #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // read ports
  input  logic [NumPorts-1:0]                          rd_req_i,
  input  logic [NumPorts-1:0]                          rd_prio_i,
  input  logic [NumPorts-1:0]                          rd_tag_only_i,
  input  dcache_geom_pkg::cache_idx_t [NumPorts-1:0]   rd_idx_i,
  input  dcache_word_pkg::cache_off_u [NumPorts-1:0]   rd_off_i,
  input  dcache_geom_pkg::cache_tag_t [NumPorts-1:0]   rd_tag_i,
  output logic [NumPorts-1:0]                          rd_ack_o,
  // refill on port 0
  input  logic                                         wr_cl_vld_i,
  input  dcache_geom_pkg::way_vec_t                    wr_cl_we_i,
  input  dcache_geom_pkg::cache_tag_t                  wr_cl_tag_i,
  input  dcache_geom_pkg::cache_idx_t                  wr_cl_idx_i,
  input  dcache_word_pkg::line_t                       wr_cl_data_i,
  input  dcache_word_pkg::line_be_t                    wr_cl_data_be_i,
  input  dcache_geom_pkg::way_vec_t                    wr_vld_bits_i,
  // single word write
  input  dcache_geom_pkg::way_vec_t                    wr_req_i,
  input  dcache_geom_pkg::cache_idx_t                  wr_idx_i,
  input  dcache_word_pkg::cache_off_u                  wr_off_i,
  input  dcache_word_pkg::data_word_t                  wr_data_i,
  input  dcache_word_pkg::word_be_t                    wr_be_i,
  output logic                                         wr_ack_o,
  // memory side
  dcache_tag_if.ctrl_mp                                tag_o,
  dcache_bank_if.ctrl_mp                               bank_o,
  // compare stage
  output logic                                         cmp_en_o,
  output logic                                         rd_bank_o,
  output dcache_geom_pkg::cache_tag_t                  rd_tag_o
);

  localparam int unsigned PortIdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic [NumPorts-1:0]     req_prio;
  logic [NumPorts-1:0]     req_masked;
  logic [PortIdxWidth-1:0] rr_q;
  logic [PortIdxWidth-1:0] gnt_idx;
  logic [PortIdxWidth-1:0] sel_q;
  logic                    rd_found;
  logic                    rd_acked;
  logic                    rd_bank;
  logic                    wr_bank;
  logic                    bank_q;
  logic                    cmp_en_q;

  ////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////

  // high priority requests hide all low priority ones
  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  // round robin, search starts one past the last grant
  always_comb begin : p_arb
    int unsigned cand;
    rd_found = 1'b0;
    gnt_idx  = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = rr_q + i;
      if (cand >= NumPorts) begin
        cand = cand - NumPorts;
      end
      if (!rd_found && req_masked[cand]) begin
        rd_found = 1'b1;
        gnt_idx  = cand[PortIdxWidth-1:0];
      end
    end
  end

  // a refill takes the arrays for the whole cycle
  assign rd_acked = rd_found & ~wr_cl_vld_i;

  always_comb begin : p_ack
    for (int unsigned k = 0; k < NumPorts; k++) begin
      rd_ack_o[k] = rd_acked && (gnt_idx == k);
    end
  end

  assign rd_bank = rd_off_i[gnt_idx].fld.bank;
  assign wr_bank = wr_off_i.fld.bank;

  // word write only loses against a data read of the same bank
  assign wr_ack_o = ~wr_cl_vld_i & (|wr_req_i) &
                    (~rd_acked | rd_tag_only_i[gnt_idx] | (rd_bank != wr_bank));

  ////////////////////////////////////////
  // tag and bank requests
  ////////////////////////////////////////

  // reads look up all ways, refills write the selected ones
  assign tag_o.req    = wr_cl_vld_i ? wr_cl_we_i : {dcache_geom_pkg::NumWays{rd_acked}};
  assign tag_o.we     = wr_cl_vld_i;
  assign tag_o.idx    = wr_cl_vld_i ? wr_cl_idx_i : rd_idx_i[gnt_idx];
  assign tag_o.wtag   = wr_cl_tag_i;
  assign tag_o.wvalid = wr_vld_bits_i;

  always_comb begin : p_bank
    bank_o.req = '0;
    bank_o.we  = '0;
    bank_o.idx = {dcache_word_pkg::NumBanks{wr_idx_i}};
    for (int k = 0; k < dcache_word_pkg::NumBanks; k++) begin
      for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
        bank_o.be[k][w]    = '0;
        bank_o.wdata[k][w] = wr_cl_vld_i ? wr_cl_data_i[k*64 +: 64] : wr_data_i;
      end
    end

    if (wr_cl_vld_i) begin
      // refill spans both banks, word k of the line goes to bank k
      bank_o.req = {dcache_word_pkg::NumBanks{|wr_cl_we_i}};
      bank_o.we  = {dcache_word_pkg::NumBanks{|wr_cl_we_i}};
      bank_o.idx = {dcache_word_pkg::NumBanks{wr_cl_idx_i}};
      for (int k = 0; k < dcache_word_pkg::NumBanks; k++) begin
        for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
          bank_o.be[k][w] = wr_cl_we_i[w] ? wr_cl_data_be_i[k*8 +: 8] : '0;
        end
      end
    end else begin
      if (rd_acked && !rd_tag_only_i[gnt_idx]) begin
        bank_o.req[rd_bank] = 1'b1;
        bank_o.idx[rd_bank] = rd_idx_i[gnt_idx];
      end
      if (wr_ack_o) begin
        bank_o.req[wr_bank] = 1'b1;
        bank_o.we[wr_bank]  = 1'b1;
        bank_o.idx[wr_bank] = wr_idx_i;
        for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
          bank_o.be[wr_bank][w] = wr_req_i[w] ? wr_be_i : '0;
        end
      end
    end
  end

  ////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rr_q     <= '0;
      sel_q    <= '0;
      bank_q   <= 1'b0;
      cmp_en_q <= 1'b0;
    end else begin
      cmp_en_q <= rd_acked;
      if (rd_acked) begin
        rr_q   <= (gnt_idx == PortIdxWidth'(NumPorts - 1)) ? '0 : gnt_idx + 1'b1;
        sel_q  <= gnt_idx;
        bank_q <= rd_bank;
      end
    end
  end

  assign cmp_en_o  = cmp_en_q;
  assign rd_bank_o = bank_q;
  // the tag of the granted port arrives one cycle after its ack
  assign rd_tag_o  = rd_tag_i[sel_q];

endmodule

//--- design/dcache_tag_array.sv
////////////////////////////////////////
// tag memory and valid bits per way, read data one cycle after req
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_tag_array (
  input  logic           clk_i,
  input  logic           rst_ni,
  dcache_tag_if.array_mp tag_i
);

  dcache_geom_pkg::cache_tag_t
    tag_mem [dcache_geom_pkg::NumWays][dcache_geom_pkg::NumSets];
  dcache_geom_pkg::way_vec_t valid_q [dcache_geom_pkg::NumSets];

  // tag storage and read port
  always_ff @(posedge clk_i) begin : p_tag_mem
    for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
      if (tag_i.req[w]) begin
        if (tag_i.we) begin
          tag_mem[w][tag_i.idx] <= tag_i.wtag;
        end else begin
          tag_i.rtag[w] <= tag_mem[w][tag_i.idx];
        end
      end
    end
  end

  // valid bits are flops so reset can clear all sets
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      valid_q      <= '{default: '0};
      tag_i.rvalid <= '0;
    end else begin
      for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
        if (tag_i.req[w]) begin
          if (tag_i.we) begin
            valid_q[tag_i.idx][w] <= tag_i.wvalid[w];
          end else begin
            tag_i.rvalid[w] <= valid_q[tag_i.idx][w];
          end
        end
      end
    end
  end

endmodule

//--- design/dcache_data_banks.sv
////////////////////////////////////////
// two data SRAM banks, each entry holds one word of every way
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_data_banks (
  input  logic            clk_i,
  dcache_bank_if.banks_mp bank_i
);

  dcache_word_pkg::data_word_t [dcache_geom_pkg::NumWays-1:0]
    bank_mem [dcache_word_pkg::NumBanks][dcache_geom_pkg::NumSets];

  always_ff @(posedge clk_i) begin : p_banks
    for (int k = 0; k < dcache_word_pkg::NumBanks; k++) begin
      if (bank_i.req[k]) begin
        if (bank_i.we[k]) begin
          // byte-wise write of every way
          for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
            for (int b = 0; b < 8; b++) begin
              if (bank_i.be[k][w][b]) begin
                bank_mem[k][bank_i.idx[k]][w][b*8 +: 8] <= bank_i.wdata[k][w][b*8 +: 8];
              end
            end
          end
        end else begin
          bank_i.rdata[k] <= bank_mem[k][bank_i.idx[k]];
        end
      end
    end
  end

endmodule

//--- design/dcache_hit_select.sv
////////////////////////////////////////
// tag compare of the looked-up set and read mux of the hitting way
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_hit_select (
  dcache_tag_if.cmp_mp                tag_i,
  dcache_bank_if.cmp_mp               bank_i,
  input  logic                        cmp_en_i,
  input  logic                        rd_bank_i,
  input  dcache_geom_pkg::cache_tag_t rd_tag_i,
  output dcache_geom_pkg::way_vec_t   rd_hit_oh_o,
  output dcache_geom_pkg::way_vec_t   rd_vld_bits_o,
  output dcache_word_pkg::data_word_t rd_data_o
);

  dcache_geom_pkg::way_idx_t hit_way;

  // hit needs a matching tag, a set valid bit and a read in compare
  always_comb begin : p_cmp
    for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
      rd_hit_oh_o[w] = cmp_en_i && tag_i.rvalid[w] && (tag_i.rtag[w] == rd_tag_i);
    end
  end

  assign rd_vld_bits_o = tag_i.rvalid;

  // lowest hitting way wins
  always_comb begin : p_way
    hit_way = '0;
    for (int w = dcache_geom_pkg::NumWays - 1; w >= 0; w--) begin
      if (rd_hit_oh_o[w]) begin
        hit_way = dcache_geom_pkg::way_idx_t'(w);
      end
    end
  end

  assign rd_data_o = (|rd_hit_oh_o) ? bank_i.rdata[rd_bank_i][hit_way] : '0;

endmodule

//--- design/dcache_mem_top.sv
////////////////////////////////////////
// memory stage of the write-through L1 data cache, plain port top level
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_mem_top #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // read ports
  input  logic [NumPorts-1:0]                          rd_req_i,
  input  logic [NumPorts-1:0]                          rd_prio_i,
  input  logic [NumPorts-1:0]                          rd_tag_only_i,
  input  dcache_geom_pkg::cache_idx_t [NumPorts-1:0]   rd_idx_i,
  input  dcache_word_pkg::cache_off_u [NumPorts-1:0]   rd_off_i,
  input  dcache_geom_pkg::cache_tag_t [NumPorts-1:0]   rd_tag_i,
  output logic [NumPorts-1:0]                          rd_ack_o,
  output dcache_geom_pkg::way_vec_t                    rd_hit_oh_o,
  output dcache_geom_pkg::way_vec_t                    rd_vld_bits_o,
  output dcache_word_pkg::data_word_t                  rd_data_o,
  // refill
  input  logic                                         wr_cl_vld_i,
  input  dcache_geom_pkg::way_vec_t                    wr_cl_we_i,
  input  dcache_geom_pkg::cache_tag_t                  wr_cl_tag_i,
  input  dcache_geom_pkg::cache_idx_t                  wr_cl_idx_i,
  input  dcache_word_pkg::line_t                       wr_cl_data_i,
  input  dcache_word_pkg::line_be_t                    wr_cl_data_be_i,
  input  dcache_geom_pkg::way_vec_t                    wr_vld_bits_i,
  // single word write
  input  dcache_geom_pkg::way_vec_t                    wr_req_i,
  input  dcache_geom_pkg::cache_idx_t                  wr_idx_i,
  input  dcache_word_pkg::cache_off_u                  wr_off_i,
  input  dcache_word_pkg::data_word_t                  wr_data_i,
  input  dcache_word_pkg::word_be_t                    wr_be_i,
  output logic                                         wr_ack_o
);

  logic                        cmp_en;
  logic                        rd_bank;
  dcache_geom_pkg::cache_tag_t rd_tag;

  dcache_tag_if  tag_if ();
  dcache_bank_if bank_if ();

  dcache_access_ctrl #(
    .NumPorts (NumPorts)
  ) i_access_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rd_req_i        (rd_req_i),
    .rd_prio_i       (rd_prio_i),
    .rd_tag_only_i   (rd_tag_only_i),
    .rd_idx_i        (rd_idx_i),
    .rd_off_i        (rd_off_i),
    .rd_tag_i        (rd_tag_i),
    .rd_ack_o        (rd_ack_o),
    .wr_cl_vld_i     (wr_cl_vld_i),
    .wr_cl_we_i      (wr_cl_we_i),
    .wr_cl_tag_i     (wr_cl_tag_i),
    .wr_cl_idx_i     (wr_cl_idx_i),
    .wr_cl_data_i    (wr_cl_data_i),
    .wr_cl_data_be_i (wr_cl_data_be_i),
    .wr_vld_bits_i   (wr_vld_bits_i),
    .wr_req_i        (wr_req_i),
    .wr_idx_i        (wr_idx_i),
    .wr_off_i        (wr_off_i),
    .wr_data_i       (wr_data_i),
    .wr_be_i         (wr_be_i),
    .wr_ack_o        (wr_ack_o),
    .tag_o           (tag_if.ctrl_mp),
    .bank_o          (bank_if.ctrl_mp),
    .cmp_en_o        (cmp_en),
    .rd_bank_o       (rd_bank),
    .rd_tag_o        (rd_tag)
  );

  dcache_tag_array i_tag_array (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tag_i  (tag_if.array_mp)
  );

  dcache_data_banks i_data_banks (
    .clk_i  (clk_i),
    .bank_i (bank_if.banks_mp)
  );

  dcache_hit_select i_hit_select (
    .tag_i         (tag_if.cmp_mp),
    .bank_i        (bank_if.cmp_mp),
    .cmp_en_i      (cmp_en),
    .rd_bank_i     (rd_bank),
    .rd_tag_i      (rd_tag),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

//--- verif/dcache_mem_tasks.svh
////////////////////////////////////////
// reference model, drivers and checks of the memory stage testbench
// included inside the testbench module
////////////////////////////////////////

`ifndef DCACHE_MEM_TASKS_SVH
`define DCACHE_MEM_TASKS_SVH

// expected contents, updated on refills and acknowledged word writes
dcache_word_pkg::line_t model_line [dcache_geom_pkg::NumWays][dcache_geom_pkg::NumSets];
tag_t                   model_tag [dcache_geom_pkg::NumWays][dcache_geom_pkg::NumSets];
ways_t                  model_vld [dcache_geom_pkg::NumSets] = '{default: '0};

task automatic fail_run(input string msg);
  $display("%s", msg);
  $display("Finished with errors");
  $fatal(1, "stopped at the first failing check");
endtask

task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
  assert (act === exp) else begin
    fail_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act));
  end
endtask

// inputs change 2 ns after the rising edge
task automatic tick();
  @(posedge clk_i);
  #2;
endtask

// way number in the low bits keeps the tags of one set distinct
function automatic tag_t make_tag(input int way);
  return {1'b0, 19'($urandom), 2'(way)};
endfunction

// word of the lowest hitting way, zero on a miss
function automatic dcache_word_pkg::data_word_t expected_word(input ways_t hit, input idx_t idx,
                                                              input logic bank);
  for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
    if (hit[w]) begin
      return model_line[w][idx][64*bank +: 64];
    end
  end
  return '0;
endfunction

// byte merge of the word write currently driven
task automatic merge_word(input ways_t ways, input idx_t idx, input logic bank);
  for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
    for (int b = 0; b < 8; b++) begin
      if (ways[w] && wr_be_i[b]) begin
        model_line[w][idx][64*bank + 8*b +: 8] = wr_data_i[8*b +: 8];
      end
    end
  end
endtask

// one-cycle refill, any pending read or word write must stay blocked
task automatic refill(input ways_t ways, input idx_t idx, input tag_t tag, input ways_t vld);
  dcache_word_pkg::line_t line;
  line          = {$urandom, $urandom, $urandom, $urandom};
  wr_cl_vld_i   = 1'b1;
  wr_cl_we_i    = ways;
  wr_cl_idx_i   = idx;
  wr_cl_tag_i   = tag;
  wr_cl_data_i  = line;
  wr_vld_bits_i = vld;
  @(negedge clk_i);
  check_val("refill blocks reads", '0, rd_ack_o);
  check_val("refill blocks word write", '0, wr_ack_o);
  tick();
  wr_cl_vld_i = 1'b0;
  for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
    if (ways[w]) begin
      model_tag[w][idx]  = tag;
      model_line[w][idx] = line;
      model_vld[idx][w]  = vld[w];
    end
  end
endtask

// read on one port, optionally with a word write to the same set in the same cycle
task automatic read_access(input string name, input int port, input idx_t idx, input logic bank,
                           input tag_t tag, input logic tag_only, input ways_t exp_hit,
                           input ways_t wr_ways, input logic wr_bank, input logic exp_wr_ack);
  ways_t                       exp_vld;
  dcache_word_pkg::data_word_t exp_data;
  logic                        wr_done;
  exp_vld                 = model_vld[idx];
  exp_data                = expected_word(exp_hit, idx, bank);
  rd_req_i[port]          = 1'b1;
  rd_idx_i[port]          = idx;
  rd_off_i[port].fld.bank = bank;
  rd_tag_only_i[port]     = tag_only;
  wr_req_i                = wr_ways;
  wr_idx_i                = idx;
  wr_off_i.fld.bank       = wr_bank;
  wr_data_i               = {$urandom, $urandom};
  wr_be_i                 = 8'($urandom);
  @(negedge clk_i);
  while (rd_ack_o[port] !== 1'b1) begin
    tick();
    @(negedge clk_i);
  end
  check_val({name, " grant"}, 1 << port, rd_ack_o);
  wr_done = wr_ack_o;
  if (wr_ways != '0) begin
    check_val({name, " write ack"}, exp_wr_ack, wr_done);
  end
  if (wr_done) begin
    merge_word(wr_ways, idx, wr_bank);
  end
  tick();
  // compare cycle, the tag follows the grant
  rd_req_i[port] = 1'b0;
  rd_tag_i[port] = tag;
  if (wr_done) begin
    wr_req_i = '0;
  end
  @(negedge clk_i);
  check_val({name, " hit"}, exp_hit, rd_hit_oh_o);
  check_val({name, " valid bits"}, exp_vld, rd_vld_bits_o);
  if (!tag_only) begin
    check_val({name, " data"}, exp_data, rd_data_o);
  end
  if (wr_req_i != '0) begin
    while (wr_ack_o !== 1'b1) begin
      tick();
      @(negedge clk_i);
    end
    merge_word(wr_ways, idx, wr_bank);
  end
  tick();
  wr_req_i = '0;
endtask

`endif

//--- verif/dcache_mem_tb.sv
////////////////////////////////////////
// directed testbench of the data cache memory stage
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_mem_tb;

  localparam int unsigned NumPorts      = 3;
  localparam int unsigned TimeoutCycles = 2000;

  typedef dcache_geom_pkg::cache_idx_t idx_t;
  typedef dcache_geom_pkg::cache_tag_t tag_t;
  typedef dcache_geom_pkg::way_vec_t   ways_t;

  logic                                       clk_i           = 1'b0;
  logic                                       rst_ni          = 1'b0;
  logic [NumPorts-1:0]                        rd_req_i        = '0;
  logic [NumPorts-1:0]                        rd_prio_i       = '0;
  logic [NumPorts-1:0]                        rd_tag_only_i   = '0;
  idx_t [NumPorts-1:0]                        rd_idx_i        = '0;
  dcache_word_pkg::cache_off_u [NumPorts-1:0] rd_off_i        = '0;
  tag_t [NumPorts-1:0]                        rd_tag_i        = '0;
  logic                                       wr_cl_vld_i     = 1'b0;
  ways_t                                      wr_cl_we_i      = '0;
  tag_t                                       wr_cl_tag_i     = '0;
  idx_t                                       wr_cl_idx_i     = '0;
  dcache_word_pkg::line_t                     wr_cl_data_i    = '0;
  dcache_word_pkg::line_be_t                  wr_cl_data_be_i = '1;
  ways_t                                      wr_vld_bits_i   = '0;
  ways_t                                      wr_req_i        = '0;
  idx_t                                       wr_idx_i        = '0;
  dcache_word_pkg::cache_off_u                wr_off_i        = '0;
  dcache_word_pkg::data_word_t                wr_data_i       = '0;
  dcache_word_pkg::word_be_t                  wr_be_i         = '0;
  logic [NumPorts-1:0]                        rd_ack_o;
  ways_t                                      rd_hit_oh_o;
  ways_t                                      rd_vld_bits_o;
  dcache_word_pkg::data_word_t                rd_data_o;
  logic                                       wr_ack_o;
  int unsigned                                cycle_cnt       = 0;

  dcache_mem_top #(.NumPorts(NumPorts)) i_dut (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      fail_run("timeout: the DUT did not finish the test sequence within the cycle limit");
    end
  end

  `include "dcache_mem_tasks.svh"

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  // all ports held for round robin and then one high priority port at a time
  task automatic arbitration_test();
    rd_req_i = '1;
    for (int i = 0; i < 6; i++) begin
      @(negedge clk_i);
      check_val("round robin grant", 1 << (i % NumPorts), rd_ack_o);
      tick();
    end
    for (int p = NumPorts - 1; p >= 1; p--) begin
      rd_prio_i = NumPorts'(1 << p);
      repeat (2) begin
        @(negedge clk_i);
        check_val("priority grant", 1 << p, rd_ack_o);
        tick();
      end
    end
    rd_req_i  = '0;
    rd_prio_i = '0;
    tick();
  endtask

  task automatic refill_hit_test();
    idx_t sets [4] = '{6'd3, 6'd17, 6'd42, 6'd63};
    foreach (sets[s]) begin
      for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
        refill(ways_t'(1 << w), sets[s], make_tag(w), 4'hf);
      end
    end
    foreach (sets[s]) begin
      for (int w = 0; w < dcache_geom_pkg::NumWays; w++) begin
        for (int b = 0; b < 2; b++) begin
          read_access("refill then hit", (w + b) % NumPorts, sets[s], b[0],
                      model_tag[w][sets[s]], 1'b0, ways_t'(1 << w), '0, 1'b0, 1'b0);
        end
      end
    end
  endtask

  task automatic miss_valid_test();
    read_access("miss", 0, 6'd17, 1'b0, {1'b1, 21'($urandom)}, 1'b0, '0, '0, 1'b0, 1'b0);
    // same tag written back with its valid bit clear
    refill(4'b0100, 6'd17, model_tag[2][17], '0);
    read_access("cleared valid", 1, 6'd17, 1'b1, model_tag[2][17], 1'b0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic tag_only_test();
    read_access("tag-only", 2, 6'd42, 1'b1, model_tag[3][42], 1'b1, 4'b1000, '0, 1'b0, 1'b0);
    read_access("tag-only with write", 0, 6'd42, 1'b0, model_tag[0][42], 1'b1, 4'b0001,
                4'b0010, 1'b0, 1'b1);
    read_access("tag-only write readback", 1, 6'd42, 1'b0, model_tag[1][42], 1'b0, 4'b0010,
                '0, 1'b0, 1'b0);
  endtask

  task automatic word_write_test();
    read_access("write same bank", 2, 6'd63, 1'b1, model_tag[1][63], 1'b0, 4'b0010,
                4'b0001, 1'b1, 1'b0);
    read_access("write other bank", 0, 6'd63, 1'b1, model_tag[2][63], 1'b0, 4'b0100,
                4'b0100, 1'b0, 1'b1);
    read_access("merged bytes way 0", 1, 6'd63, 1'b1, model_tag[0][63], 1'b0, 4'b0001,
                '0, 1'b0, 1'b0);
    read_access("merged bytes way 2", 2, 6'd63, 1'b0, model_tag[2][63], 1'b0, 4'b0100,
                '0, 1'b0, 1'b0);
  endtask

  // read and word write stay pending during the refill
  task automatic refill_block_test();
    rd_req_i[1] = 1'b1;
    rd_idx_i[1] = 6'd10;
    wr_req_i    = 4'b0001;
    refill(4'b0001, 6'd10, make_tag(0), 4'hf);
    rd_req_i = '0;
    wr_req_i = '0;
    read_access("hit after refill", 1, 6'd10, 1'b1, model_tag[0][10], 1'b0, 4'b0001,
                '0, 1'b0, 1'b0);
  endtask

  initial begin
    void'($urandom(33));
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    arbitration_test();
    refill_hit_test();
    miss_valid_test();
    tag_only_test();
    word_write_test();
    refill_block_test();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- all.f
+incdir+verif
design/dcache_geom_pkg.sv
design/dcache_word_pkg.sv
design/dcache_tag_if.sv
design/dcache_bank_if.sv
design/dcache_access_ctrl.sv
design/dcache_tag_array.sv
design/dcache_data_banks.sv
design/dcache_hit_select.sv
design/dcache_mem_top.sv
verif/dcache_mem_tb.sv

//--- Bender.yml
package:
  name: dcache_mem

sources:
  - files:
      - design/dcache_geom_pkg.sv
      - design/dcache_word_pkg.sv
      - design/dcache_tag_if.sv
      - design/dcache_bank_if.sv
      - design/dcache_access_ctrl.sv
      - design/dcache_tag_array.sv
      - design/dcache_data_banks.sv
      - design/dcache_hit_select.sv
      - design/dcache_mem_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/dcache_mem_tb.sv
